//--- compile.f
verilog/video_pkg.sv
verilog/video_timer.sv
verilog/tile_layer.sv
verilog/sprite_layer.sv
verilog/colour_mix.sv
verilog/video_top.sv
testbench/video_checks.sv
testbench/video_tb.sv

//--- testbench/video_tb.sv
/* Video subsystem testbench
   Loads palette and patterns, writes the map, scroll and sprite table,
   then runs frames with each layer combination under video_checks */

`timescale 1ns/1ns
`default_nettype none

module video_tb;

    import video_pkg::*;

    localparam int CLK_NS       = 8;
    localparam int FRAME_NS     = H_TOTAL * V_TOTAL * 2 * CLK_NS;
    localparam int SETUP_CYCLES = 16 + PAL_SIZE + SPR_SIZE + TILE_SIZE + 4 * (33 + 16) + 8;
    // First sync pulse arrives within one frame, five more frames follow
    localparam int WATCHDOG_NS  = SETUP_CYCLES * CLK_NS + 6 * FRAME_NS;

    logic              clk;
    logic              reset;
    logic              pxl_cen;
    logic [CPU_AW-1:0] cpu_addr;
    logic [7:0]        cpu_dout;
    logic              cpu_rnw;
    logic              vram_cs;
    logic              objram_cs;
    logic              prom_en;
    logic [PROG_AW-1:0] prog_addr;
    logic [7:0]        prog_data;
    logic [1:0]        gfx_en;
    logic              check_pixels;
    logic              check_failed;
    logic [7:0]        vram_dout;
    logic [7:0]        obj_dout;
    logic              hs;
    logic              vs;
    logic              lhbl;
    logic              lvbl;
    logic [3:0]        red;
    logic [3:0]        green;
    logic [3:0]        blue;
    integer            seed;

    // x, y, code, enable per sprite; 0 and 1 overlap, 3 is off
    logic [7:0] sprite_table [4*N_SPRITES] = '{
        8'd10, 8'd4,  8'd1, 8'd1,
        8'd14, 8'd8,  8'd2, 8'd1,
        8'd60, 8'd26, 8'd3, 8'd1,
        8'd12, 8'd6,  8'd0, 8'd0
    };

    video_top uut (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_rnw   ( cpu_rnw   ),
        .vram_cs   ( vram_cs   ),
        .objram_cs ( objram_cs ),
        .prom_en   ( prom_en   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .gfx_en    ( gfx_en    ),
        .vram_dout ( vram_dout ),
        .obj_dout  ( obj_dout  ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    video_checks u_checks (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .pxl_cen      ( pxl_cen      ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .cpu_rnw      ( cpu_rnw      ),
        .vram_cs      ( vram_cs      ),
        .objram_cs    ( objram_cs    ),
        .prom_en      ( prom_en      ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .gfx_en       ( gfx_en       ),
        .check_pixels ( check_pixels ),
        .vram_dout    ( vram_dout    ),
        .obj_dout     ( obj_dout     ),
        .hs           ( hs           ),
        .vs           ( vs           ),
        .lhbl         ( lhbl         ),
        .lvbl         ( lvbl         ),
        .red          ( red          ),
        .green        ( green        ),
        .blue         ( blue         ),
        .failed       ( check_failed )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Pixel enable on every second clk
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(negedge clk);
            pxl_cen = ~pxl_cen;
        end
    end

    task automatic load_byte(input int addr, input int data);
        @(negedge clk);
        prom_en   = 1'b1;
        prog_addr = PROG_AW'(addr);
        prog_data = 8'(data);
    endtask

    // Single-cycle select, obj picks the sprite table
    task automatic cpu_access(input logic obj, input logic rnw, input int addr, input int data);
        @(negedge clk);
        cpu_addr  = CPU_AW'(addr);
        cpu_dout  = 8'(data);
        cpu_rnw   = rnw;
        vram_cs   = !obj;
        objram_cs = obj;
        @(negedge clk);
        vram_cs   = 1'b0;
        objram_cs = 1'b0;
        cpu_rnw   = 1'b1;
    endtask

    task automatic next_frame_with(input logic [1:0] layers);
        @(posedge vs);
        @(negedge clk);
        gfx_en = layers;
    endtask

    initial begin : stimulus
        seed         = 95627;
        reset        = 1'b1;
        cpu_addr     = '0;
        cpu_dout     = '0;
        cpu_rnw      = 1'b1;
        vram_cs      = 1'b0;
        objram_cs    = 1'b0;
        prom_en      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        gfx_en       = 2'b11;
        check_pixels = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < PAL_SIZE; i++)
            load_byte(int'(PAL_BASE) + i, $random(seed));
        for (int i = 0; i < SPR_SIZE; i++)
            load_byte(int'(SPR_BASE) + i, $random(seed));
        for (int i = 0; i < TILE_SIZE; i++)
            load_byte(int'(TILE_BASE) + i, $random(seed));
        @(negedge clk);
        prom_en = 1'b0;

        for (int i = 0; i < TILE_COLS * TILE_ROWS; i++)
            cpu_access(1'b0, 1'b0, i, $random(seed) & 15);
        // Beyond H_ACTIVE so the wrap is exercised
        cpu_access(1'b0, 1'b0, SCROLL_ADDR, 85);
        for (int i = 0; i < 4 * N_SPRITES; i++)
            cpu_access(1'b1, 1'b0, i, sprite_table[i]);
        for (int i = 0; i <= TILE_COLS * TILE_ROWS; i++)
            cpu_access(1'b0, 1'b1, i, 0);
        for (int i = 0; i < 4 * N_SPRITES; i++)
            cpu_access(1'b1, 1'b1, i, 0);

        // Start pixel checks in vertical blanking
        @(posedge vs);
        @(negedge clk);
        check_pixels = 1'b1;
        repeat (2) @(posedge vs);
        @(negedge clk);
        gfx_en = 2'b10;
        next_frame_with(2'b01);
        next_frame_with(2'b00);
        @(posedge vs);

        if (check_failed) begin
            $display("Checks failed");
            $fatal(1, "errors were reported");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    initial begin : stop_on_error
        wait (check_failed === 1'b1);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1, "timeout, the frames did not complete in time");
    end

endmodule

`default_nettype wire

//--- testbench/video_checks.sv
/* Video checker
   Shadows downloads and CPU writes, models the expected pixel at each
   visible raster position and checks sync timing, readback and RGB */

`timescale 1ns/1ns
`default_nettype none

module video_checks (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pxl_cen,
    input  logic [video_pkg::CPU_AW-1:0]   cpu_addr,
    input  logic [7:0]                     cpu_dout,
    input  logic                           cpu_rnw,
    input  logic                           vram_cs,
    input  logic                           objram_cs,
    input  logic                           prom_en,
    input  logic [video_pkg::PROG_AW-1:0]  prog_addr,
    input  logic [7:0]                     prog_data,
    input  logic [1:0]                     gfx_en,
    input  logic                           check_pixels,
    input  logic [7:0]                     vram_dout,
    input  logic [7:0]                     obj_dout,
    input  logic                           hs,
    input  logic                           vs,
    input  logic                           lhbl,
    input  logic                           lvbl,
    input  logic [3:0]                     red,
    input  logic [3:0]                     green,
    input  logic [3:0]                     blue,
    output logic                           failed
);

    import video_pkg::*;

    // Shadow copies with the scroll register as map entry 32
    logic [7:0] pal_sh  [PAL_SIZE];
    logic [7:0] spr_sh  [SPR_SIZE];
    logic [7:0] tile_sh [TILE_SIZE];
    logic [7:0] map_sh  [TILE_COLS*TILE_ROWS+1];
    logic [7:0] obj_sh  [4*N_SPRITES];

    int         cen_cnt;
    int         hs_rise;
    int         vs_rise;
    logic       hs_seen;
    logic       vs_seen;
    logic       prev_hs;
    logic       prev_vs;
    logic       prev_lhbl;
    int         px;
    int         py;
    logic       vram_pend;
    logic       obj_pend;
    logic [7:0] vram_want;
    logic [7:0] obj_want;

    task automatic flag_mismatch(input string name, input int got, input int want);
        $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
        failed = 1'b1;
    endtask

    // Pixel at raster (x, y) from the shadow memories
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        int         col;
        int         code;
        int         tpix;
        int         opix;
        int         dx;
        int         dy;
        int         idx;
        logic [7:0] pb;
        logic [7:0] sb;
        col  = (x + map_sh[SCROLL_ADDR]) % H_ACTIVE;
        code = map_sh[(y / 8) * TILE_COLS + col / 8] % 16;
        // 32 bytes per 8x8 pattern and 4 per row
        pb   = tile_sh[code * 32 + (y % 8) * 4 + (col % 8) / 2];
        tpix = (col % 2) ? pb[7:4] : pb[3:0];
        if (!gfx_en[0])
            tpix = 0;
        opix = 0;
        for (int i = 0; i < N_SPRITES; i++) begin
            dx = x - int'(obj_sh[4*i]);
            dy = y - int'(obj_sh[4*i+1]);
            if (opix == 0 && obj_sh[4*i+3][0] && dx >= 0 && dx < 8 && dy >= 0 && dy < 8) begin
                sb   = spr_sh[(obj_sh[4*i+2] % 4) * 32 + dy * 4 + dx / 2];
                opix = (dx % 2) ? sb[7:4] : sb[3:0];
            end
        end
        if (!gfx_en[1])
            opix = 0;
        idx = (opix != 0) ? 16 + opix : tpix;
        return {pal_sh[2*idx+1][3:0], pal_sh[2*idx]};
    endfunction

    always @(posedge clk) begin : check_loop
        int          off;
        logic [11:0] want;
        int          pos;
        int          dly;
        logic        want_hs;
        logic        want_hb;
        logic        want_vb;
        if (reset) begin
            failed    = 1'b0;
            cen_cnt   = 0;
            hs_seen   = 1'b0;
            vs_seen   = 1'b0;
            prev_hs   = 1'b0;
            prev_vs   = 1'b0;
            prev_lhbl = 1'b0;
            px        = 0;
            py        = 0;
            vram_pend = 1'b0;
            obj_pend  = 1'b0;
        end else begin
            // Readback of the select one clk ago
            if (vram_pend)
                assert (vram_dout == vram_want)
                else flag_mismatch("vram_dout", vram_dout, vram_want);
            if (obj_pend)
                assert (obj_dout == obj_want)
                else flag_mismatch("obj_dout", obj_dout, obj_want);
            vram_pend = vram_cs;
            obj_pend  = objram_cs;
            if (vram_cs)
                vram_want = cpu_rnw ? map_sh[cpu_addr] : cpu_dout;
            if (objram_cs)
                obj_want = cpu_rnw ? obj_sh[cpu_addr] : cpu_dout;
            if (vram_cs && !cpu_rnw)
                map_sh[cpu_addr] = cpu_dout;
            if (objram_cs && !cpu_rnw)
                obj_sh[cpu_addr] = cpu_dout;

            if (prom_en) begin
                off = int'(prog_addr);
                if (off >= int'(PAL_BASE) && off < int'(PAL_BASE) + PAL_SIZE)
                    pal_sh[off - int'(PAL_BASE)] = prog_data;
                if (off >= int'(SPR_BASE) && off < int'(SPR_BASE) + SPR_SIZE)
                    spr_sh[off - int'(SPR_BASE)] = prog_data;
                if (off >= int'(TILE_BASE) && off < int'(TILE_BASE) + TILE_SIZE)
                    tile_sh[off - int'(TILE_BASE)] = prog_data;
            end

            if (!lhbl || !lvbl)
                assert ({red, green, blue} == 12'd0)
                else flag_mismatch("blanked rgb", {red, green, blue}, 0);

            if (pxl_cen) begin
                cen_cnt = cen_cnt + 1;
                // Sync periods and widths in pixel enables
                if (hs && !prev_hs) begin
                    if (hs_seen)
                        assert (cen_cnt - hs_rise == H_TOTAL)
                        else flag_mismatch("hs period", cen_cnt - hs_rise, H_TOTAL);
                    hs_rise = cen_cnt;
                    hs_seen = 1'b1;
                end
                if (!hs && prev_hs)
                    assert (cen_cnt - hs_rise == HS_END - HS_START + 1)
                    else flag_mismatch("hs width", cen_cnt - hs_rise, HS_END - HS_START + 1);
                if (vs && !prev_vs) begin
                    if (vs_seen)
                        assert (cen_cnt - vs_rise == H_TOTAL * V_TOTAL)
                        else flag_mismatch("vs period", cen_cnt - vs_rise, H_TOTAL * V_TOTAL);
                    vs_rise = cen_cnt;
                    vs_seen = 1'b1;
                end
                if (!vs && prev_vs)
                    assert (cen_cnt - vs_rise == (VS_END - VS_START + 1) * H_TOTAL)
                    else flag_mismatch("vs width", cen_cnt - vs_rise,
                                       (VS_END - VS_START + 1) * H_TOTAL);
                prev_hs = hs;
                prev_vs = vs;

                // Frame position anchored on the VS rise, which comes at hdump 0
                if (vs_seen) begin
                    pos     = (cen_cnt - vs_rise + VS_START * H_TOTAL) % (H_TOTAL * V_TOTAL);
                    // Blanking outputs lag the count by the pixel pipeline
                    dly     = (pos + H_TOTAL * V_TOTAL - PXL_DLY) % (H_TOTAL * V_TOTAL);
                    want_hs = pos % H_TOTAL >= HS_START && pos % H_TOTAL <= HS_END;
                    want_hb = dly % H_TOTAL < H_ACTIVE;
                    want_vb = dly / H_TOTAL < V_ACTIVE;
                    assert (hs == want_hs)
                    else flag_mismatch("hs", hs, want_hs);
                    assert (lhbl == want_hb)
                    else flag_mismatch("lhbl", lhbl, want_hb);
                    assert (lvbl == want_vb)
                    else flag_mismatch("lvbl", lvbl, want_vb);
                end

                // Raster position counted from the delayed blanking
                if (lhbl && lvbl) begin
                    if (check_pixels) begin
                        want = expected_rgb(px, py);
                        assert ({red, green, blue} == want)
                        else flag_mismatch($sformatf("rgb at x %0d y %0d", px, py),
                                           {red, green, blue}, want);
                    end
                    px = px + 1;
                end else begin
                    px = 0;
                end
                if (prev_lhbl && !lhbl && lvbl)
                    py = py + 1;
                if (!lvbl)
                    py = 0;
                prev_lhbl = lhbl;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_top.sv
/* Video subsystem top
   Raster timer feeding a tile layer and a sprite layer in parallel,
   merged by the colour mixer into RGB */

`timescale 1ns/1ns
`default_nettype none

module video_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pxl_cen,
    input  logic [video_pkg::CPU_AW-1:0]   cpu_addr,
    input  logic [7:0]                     cpu_dout,
    input  logic                           cpu_rnw,
    input  logic                           vram_cs,
    input  logic                           objram_cs,
    input  logic                           prom_en,
    input  logic [video_pkg::PROG_AW-1:0]  prog_addr,
    input  logic [7:0]                     prog_data,
    input  logic [1:0]                     gfx_en,
    output logic [7:0]                     vram_dout,
    output logic [7:0]                     obj_dout,
    output logic                           hs,
    output logic                           vs,
    output logic                           lhbl,
    output logic                           lvbl,
    output logic [3:0]                     red,
    output logic [3:0]                     green,
    output logic [3:0]                     blue
);

    import video_pkg::*;

    logic [HW-1:0]    hdump;
    logic [VW-1:0]    vdump;
    logic             pre_lhbl;
    logic             pre_lvbl;
    logic [PXL_W-1:0] tile_pxl;
    logic [PXL_W-1:0] obj_pxl;

    video_timer u_timer (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .pre_lhbl ( pre_lhbl ),
        .pre_lvbl ( pre_lvbl )
    );

    tile_layer u_tile (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_rnw   ( cpu_rnw   ),
        .vram_cs   ( vram_cs   ),
        .prom_en   ( prom_en   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .layer_en  ( gfx_en[0] ),
        .vram_dout ( vram_dout ),
        .tile_pxl  ( tile_pxl  )
    );

    sprite_layer u_obj (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_rnw   ( cpu_rnw   ),
        .objram_cs ( objram_cs ),
        .prom_en   ( prom_en   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .layer_en  ( gfx_en[1] ),
        .obj_dout  ( obj_dout  ),
        .obj_pxl   ( obj_pxl   )
    );

    colour_mix u_colmix (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .tile_pxl  ( tile_pxl  ),
        .obj_pxl   ( obj_pxl   ),
        .pre_lhbl  ( pre_lhbl  ),
        .pre_lvbl  ( pre_lvbl  ),
        .prom_en   ( prom_en   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

endmodule

`default_nettype wire

//--- verilog/colour_mix.sv
/* Colour mixer
   Sprite-over-tile priority, 32-entry palette lookup, blanking delay
   matched to the layer pipeline, and blanked 4:4:4 RGB output */

`timescale 1ns/1ns
`default_nettype none

module colour_mix (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pxl_cen,
    input  logic [video_pkg::PXL_W-1:0]    tile_pxl,
    input  logic [video_pkg::PXL_W-1:0]    obj_pxl,
    input  logic                           pre_lhbl,
    input  logic                           pre_lvbl,
    input  logic                           prom_en,
    input  logic [video_pkg::PROG_AW-1:0]  prog_addr,
    input  logic [7:0]                     prog_data,
    output logic                           lhbl,
    output logic                           lvbl,
    output logic [3:0]                     red,
    output logic [3:0]                     green,
    output logic [3:0]                     blue
);

    import video_pkg::*;

    // Low byte is green:blue, high byte holds red in bits 3:0
    logic [7:0] pal_lo [PAL_SIZE/2];
    logic [3:0] pal_hi [PAL_SIZE/2];

    logic               pal_we;
    logic [PROG_AW-1:0] pal_off;
    logic [PXL_W:0]     pal_idx;

    logic [PXL_DLY-1:0] hb_sr;
    logic [PXL_DLY-1:0] vb_sr;
    logic               show;

    assign pal_we  = prom_en && prog_addr >= PAL_BASE && prog_addr < PAL_BASE + PAL_SIZE;
    assign pal_off = prog_addr - PAL_BASE;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            if (pal_off[0])
                pal_hi[pal_off[5:1]] <= prog_data[3:0];
            else
                pal_lo[pal_off[5:1]] <= prog_data;
        end
    end

    // Any nonzero sprite pixel wins, sprites use the upper half
    assign pal_idx = obj_pxl != 0 ? {1'b1, obj_pxl} : {1'b0, tile_pxl};

    always_ff @(posedge clk) begin
        if (reset) begin
            hb_sr <= '0;
            vb_sr <= '0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[PXL_DLY-2:0], pre_lhbl};
            vb_sr <= {vb_sr[PXL_DLY-2:0], pre_lvbl};
        end
    end

    assign lhbl = hb_sr[PXL_DLY-1];
    assign lvbl = vb_sr[PXL_DLY-1];

    // Blanking for the pixel that loads on this enable
    assign show = hb_sr[PXL_DLY-2] && vb_sr[PXL_DLY-2];

    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            red   <= show ? pal_hi[pal_idx]      : 4'd0;
            green <= show ? pal_lo[pal_idx][7:4] : 4'd0;
            blue  <= show ? pal_lo[pal_idx][3:0] : 4'd0;
        end
    end

    a_blank_black: assert property (
        @(posedge clk) disable iff (reset)
        (!lhbl || !lvbl) |-> (red == 0 && green == 0 && blue == 0)
    );

endmodule

`default_nettype wire

//--- verilog/sprite_layer.sv
/* Sprite layer
   Four-entry CPU-written sprite table and downloaded sprite patterns.
   Stage 1 picks the lowest-numbered sprite with a visible pixel at the
   current position, stage 2 fetches that pixel */

`timescale 1ns/1ns
`default_nettype none

module sprite_layer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pxl_cen,
    input  logic [video_pkg::HW-1:0]       hdump,
    input  logic [video_pkg::VW-1:0]       vdump,
    input  logic [video_pkg::CPU_AW-1:0]   cpu_addr,
    input  logic [7:0]                     cpu_dout,
    input  logic                           cpu_rnw,
    input  logic                           objram_cs,
    input  logic                           prom_en,
    input  logic [video_pkg::PROG_AW-1:0]  prog_addr,
    input  logic [7:0]                     prog_data,
    input  logic                           layer_en,
    output logic [7:0]                     obj_dout,
    output logic [video_pkg::PXL_W-1:0]    obj_pxl
);

    import video_pkg::*;

    // Per sprite: x, y, pattern code, enable
    logic [7:0] obj_ram [4*N_SPRITES];
    logic [7:0] pat_ram [SPR_SIZE];

    logic               pat_we;
    logic [PROG_AW-1:0] pat_off;

    logic                        hit;
    logic [$clog2(SPR_SIZE)-1:0] hit_addr;
    logic                        hit_half;

    // Stage 1 result
    logic                        s1_hit;
    logic [$clog2(SPR_SIZE)-1:0] s1_addr;
    logic                        s1_half;

    logic [7:0]       pat_byte;
    logic [PXL_W-1:0] pat_nib;

    assign pat_we  = prom_en && prog_addr >= SPR_BASE && prog_addr < SPR_BASE + SPR_SIZE;
    assign pat_off = prog_addr - SPR_BASE;

    always_ff @(posedge clk) begin
        if (objram_cs && !cpu_rnw)
            obj_ram[cpu_addr[3:0]] <= cpu_dout;
    end

    always_ff @(posedge clk) begin
        if (objram_cs)
            obj_dout <= cpu_rnw ? obj_ram[cpu_addr[3:0]] : cpu_dout;
    end

    always_ff @(posedge clk) begin
        if (pat_we)
            pat_ram[pat_off[$clog2(SPR_SIZE)-1:0]] <= prog_data;
    end

    // Scan from the top so sprite 0 is the last one to claim the pixel
    always_comb begin : find_hit
        logic [8:0]                  dx;
        logic [8:0]                  dy;
        logic [$clog2(SPR_SIZE)-1:0] addr;
        logic [PXL_W-1:0]            pix;
        hit      = 1'b0;
        hit_addr = '0;
        hit_half = 1'b0;
        for (int i = N_SPRITES - 1; i >= 0; i--) begin
            dx   = 9'(hdump) - 9'(obj_ram[4*i]);
            dy   = 9'(vdump) - 9'(obj_ram[4*i+1]);
            addr = {obj_ram[4*i+2][1:0], dy[2:0], dx[2:1]};
            pix  = dx[0] ? pat_ram[addr][7:4] : pat_ram[addr][3:0];
            // Inside the 8x8 box without wrapping
            if (obj_ram[4*i+3][0] && dx[8:3] == 0 && dy[8:3] == 0 && pix != 0) begin
                hit      = 1'b1;
                hit_addr = addr;
                hit_half = dx[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            s1_hit <= 1'b0;
        else if (pxl_cen)
            s1_hit <= hit;
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            s1_addr <= hit_addr;
            s1_half <= hit_half;
        end
    end

    assign pat_byte = pat_ram[s1_addr];
    assign pat_nib  = s1_half ? pat_byte[7:4] : pat_byte[3:0];

    always_ff @(posedge clk) begin
        if (reset)
            obj_pxl <= '0;
        else if (pxl_cen)
            obj_pxl <= (s1_hit && layer_en) ? pat_nib : '0;
    end

    a_cpu_range: assert property (
        @(posedge clk) disable iff (reset)
        objram_cs |-> cpu_addr < 4*N_SPRITES
    );

endmodule

`default_nettype wire

//--- verilog/tile_layer.sv
/* Tile layer
   CPU-written 8x4 tile map with a horizontal scroll register, tile
   patterns loaded through the download port, and a two-stage pipeline
   turning hdump/vdump into a 4-bit tile pixel */

`timescale 1ns/1ns
`default_nettype none

module tile_layer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pxl_cen,
    input  logic [video_pkg::HW-1:0]       hdump,
    input  logic [video_pkg::VW-1:0]       vdump,
    input  logic [video_pkg::CPU_AW-1:0]   cpu_addr,
    input  logic [7:0]                     cpu_dout,
    input  logic                           cpu_rnw,
    input  logic                           vram_cs,
    input  logic                           prom_en,
    input  logic [video_pkg::PROG_AW-1:0]  prog_addr,
    input  logic [7:0]                     prog_data,
    input  logic                           layer_en,
    output logic [7:0]                     vram_dout,
    output logic [video_pkg::PXL_W-1:0]    tile_pxl
);

    import video_pkg::*;

    logic [7:0] map_ram [TILE_COLS*TILE_ROWS];
    logic [7:0] pat_ram [TILE_SIZE];
    logic [7:0] scroll;

    logic                               cpu_we;
    logic                               pat_we;
    logic [PROG_AW-1:0]                 pat_off;
    logic [$clog2(H_ACTIVE)-1:0]        col;
    logic [$clog2(TILE_COLS*TILE_ROWS)-1:0] map_addr;

    // Stage 1 payload
    logic [3:0] s1_code;
    logic [2:0] s1_x;
    logic [2:0] s1_y;

    logic [7:0]       pat_byte;
    logic [PXL_W-1:0] pat_nib;

    assign cpu_we  = vram_cs && !cpu_rnw;
    assign pat_we  = prom_en && prog_addr >= TILE_BASE && prog_addr < TILE_BASE + TILE_SIZE;
    assign pat_off = prog_addr - TILE_BASE;

    // CPU side of the map
    always_ff @(posedge clk) begin
        if (cpu_we && cpu_addr != SCROLL_ADDR)
            map_ram[cpu_addr[4:0]] <= cpu_dout;
    end

    always_ff @(posedge clk) begin
        if (reset)
            scroll <= '0;
        else if (cpu_we && cpu_addr == SCROLL_ADDR)
            scroll <= cpu_dout;
    end

    // Readback, a write returns the byte being written
    always_ff @(posedge clk) begin
        if (vram_cs) begin
            if (!cpu_rnw)
                vram_dout <= cpu_dout;
            else if (cpu_addr == SCROLL_ADDR)
                vram_dout <= scroll;
            else
                vram_dout <= map_ram[cpu_addr[4:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (pat_we)
            pat_ram[pat_off[$clog2(TILE_SIZE)-1:0]] <= prog_data;
    end

    // Scrolled column wraps over the visible width
    assign col      = hdump[$clog2(H_ACTIVE)-1:0] + scroll[$clog2(H_ACTIVE)-1:0];
    assign map_addr = {vdump[4:3], col[5:3]};

    // Stage 1: tile code and in-tile position
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            s1_code <= map_ram[map_addr][3:0];
            s1_x    <= col[2:0];
            s1_y    <= vdump[2:0];
        end
    end

    assign pat_byte = pat_ram[{s1_code, s1_y, s1_x[2:1]}];
    assign pat_nib  = s1_x[0] ? pat_byte[7:4] : pat_byte[3:0];

    // Stage 2: pattern nibble
    always_ff @(posedge clk) begin
        if (reset)
            tile_pxl <= '0;
        else if (pxl_cen)
            tile_pxl <= layer_en ? pat_nib : '0;
    end

    a_cpu_range: assert property (
        @(posedge clk) disable iff (reset)
        vram_cs |-> cpu_addr <= SCROLL_ADDR
    );

endmodule

`default_nettype wire

//--- verilog/video_timer.sv
/* Video timer
   Horizontal and vertical pixel counters advanced by the pixel enable,
   with sync pulses and blanking decoded straight from the counts */

`timescale 1ns/1ns
`default_nettype none

module video_timer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pxl_cen,
    output logic [video_pkg::HW-1:0]  hdump,
    output logic [video_pkg::VW-1:0]  vdump,
    output logic                      hs,
    output logic                      vs,
    output logic                      pre_lhbl,
    output logic                      pre_lvbl
);

    import video_pkg::*;

    logic h_last;
    logic v_last;

    assign h_last = hdump == H_TOTAL - 1;
    assign v_last = vdump == V_TOTAL - 1;

    always_ff @(posedge clk) begin
        if (reset) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hdump <= '0;
                // New line
                if (v_last)
                    vdump <= '0;
                else
                    vdump <= vdump + 1'b1;
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // Decoded from the live counts
    assign hs       = hdump >= HS_START && hdump <= HS_END;
    assign vs       = vdump >= VS_START && vdump <= VS_END;
    assign pre_lhbl = hdump < H_ACTIVE;
    assign pre_lvbl = vdump < V_ACTIVE;

    a_count_range: assert property (
        @(posedge clk) disable iff (reset)
        hdump < H_TOTAL && vdump < V_TOTAL
    );

    // One pulse covers every count from HS_START to HS_END
    a_hs_width: assert property (
        @(posedge clk) disable iff (reset)
        $rose(hs) |-> (hs throughout pxl_cen [-> HS_END - HS_START + 1]) ##1 !hs
    );

endmodule

`default_nettype wire

//--- verilog/video_pkg.sv
/* Video package
   Raster geometry, layer sizes, download map and pipeline depths
   shared by the timer, the tile and sprite layers and the colour mixer */

`default_nettype none

package video_pkg;

    // Raster geometry, counted in pixel enables
    localparam int H_TOTAL  = 80;
    localparam int H_ACTIVE = 64;
    localparam int V_TOTAL  = 48;
    localparam int V_ACTIVE = 32;
    localparam int HS_START = 68;
    localparam int HS_END   = 75;
    localparam int VS_START = 38;
    localparam int VS_END   = 39;
    localparam int HW       = 7;
    localparam int VW       = 6;

    // Layer geometry, tiles and sprites are 8x8
    localparam int PXL_W     = 4;
    localparam int TILE_COLS = 8;
    localparam int TILE_ROWS = 4;
    localparam int N_SPRITES = 4;

    // Bus widths
    localparam int PROG_AW = 10;
    localparam int CPU_AW  = 7;

    // Download map, two pixels per pattern byte with the even one in bits 3:0
    localparam logic [PROG_AW-1:0] PAL_BASE  = 10'h000;
    localparam int                 PAL_SIZE  = 64;
    localparam logic [PROG_AW-1:0] SPR_BASE  = 10'h100;
    localparam int                 SPR_SIZE  = 128;
    localparam logic [PROG_AW-1:0] TILE_BASE = 10'h200;
    localparam int                 TILE_SIZE = 512;

    // Tile CPU map, scroll sits right after the 32 map bytes
    localparam logic [CPU_AW-1:0] SCROLL_ADDR = 7'd32;

    // Pixel enables from hdump to layer pixel and to RGB
    localparam int LAYER_DLY = 2;
    localparam int PXL_DLY   = 3;

endpackage

`default_nettype wire
